// ==== mcu_pkg.sv ====
/*
  Store MCU package: width and group-multiplier codes, store modes,
  pipeline depth and the EMUL lookup table
*/
package mcu_pkg;

  // Element or memory data width, codes 0..3 mean 8, 16, 32, 64 bits
  typedef logic [2:0] width_code_t;
  // Group multiplier, codes 0..3 mean 1..8, codes 5..7 mean 1/8..1/2
  typedef logic [2:0] lmul_code_t;

  typedef enum logic {
    STORE_UNIT,
    STORE_STRIDED
  } store_mode_t;

  localparam int EMUL_ADDR_W  = 7;
  localparam int RVALID_DEPTH = 3;

  ////////////////////////////////////////////////////////////////////////////
  // EMUL table
  ////////////////////////////////////////////////////////////////////////////

  // Entry layout is {illegal, emul_code}, indexed by {dw[1:0], lmul, sew[1:0]}
  function automatic logic [3:0] emul_entry(input logic [EMUL_ADDR_W-1:0] idx);
    logic [1:0] sew;
    logic [2:0] lmul;
    logic [1:0] dw;
    int         lmul_log;
    int         emul_log;
    sew  = idx[1:0];
    lmul = idx[4:2];
    dw   = idx[6:5];
    lmul_log = (lmul[2]) ? int'(lmul) - 8 : int'(lmul);
    emul_log = lmul_log + int'(dw) - int'(sew);
    if (sew == 2'd3 || dw == 2'd3 || lmul == 3'd4 || emul_log > 3 || emul_log < -3) begin
      return 4'b1000;
    end
    // Fractional results wrap into codes 5..7
    return {1'b0, 3'(emul_log)};
  endfunction

  function automatic logic [0:127][3:0] build_emul_table();
    logic [0:127][3:0] tbl;
    for (int i = 0; i < 128; i++) begin
      tbl[i] = emul_entry(EMUL_ADDR_W'(i));
    end
    return tbl;
  endfunction

  localparam logic [0:127][3:0] EMUL_TABLE = build_emul_table();

endpackage : mcu_pkg

// ==== rd_pipe_if.sv ====
/*
  Link between the store read sequencer and the read-valid pipeline
*/
`timescale 1ns/1ps

interface rd_pipe_if;

  // Sequencer side
  logic rvalid;
  logic stall;
  logic invalidate;
  // Pipeline side
  logic tvalid;
  logic empty;

  modport seq (
    output rvalid, stall, invalidate,
    input  tvalid, empty
  );

  modport pipe (
    input  rvalid, stall, invalidate,
    output tvalid, empty
  );

endinterface : rd_pipe_if

// ==== emul_calc.sv ====
/*
  EMUL lookup for a store request, flags illegal width and multiplier pairs
*/
`timescale 1ns/1ps

module emul_calc (
  input  mcu_pkg::width_code_t sew_i,
  input  mcu_pkg::lmul_code_t  lmul_i,
  input  mcu_pkg::width_code_t data_width_i,
  output mcu_pkg::lmul_code_t  emul_o,
  output logic                 illegal_o
);

  import mcu_pkg::*;

  logic [EMUL_ADDR_W-1:0] emul_addr;
  logic [3:0]             emul_entry_w;

  // Upper width bits never select a legal entry, only the low two are used
  assign emul_addr    = {data_width_i[1:0], lmul_i, sew_i[1:0]};
  assign emul_entry_w = EMUL_TABLE[emul_addr];

  // A wide code sneaking past the index still makes the request illegal
  assign emul_o    = emul_entry_w[2:0];
  assign illegal_o = emul_entry_w[3] | sew_i[2] | data_width_i[2];

endmodule : emul_calc

// ==== store_write_fsm.sv ====
/*
  Store write sequencer: accepts the configuration from the scheduler
  and moves lane data into the store buffer
*/
`timescale 1ns/1ps

module store_write_fsm (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 st_vld_i,
  input  logic                 unit_i,
  input  logic                 strided_i,
  input  mcu_pkg::width_code_t sew_i,
  input  mcu_pkg::width_code_t data_width_i,
  input  mcu_pkg::lmul_code_t  lmul_i,
  output logic                 st_rdy_o,
  output logic                 cfg_update_o,
  output logic                 cntr_rst_o,
  output logic                 baseaddr_set_o,
  output logic                 vlane_store_rdy_o,
  output logic                 sbuff_wen_o,
  output logic                 cfg_illegal_o,
  output mcu_pkg::width_code_t cfg_data_sew_o,
  output mcu_pkg::lmul_code_t  cfg_data_lmul_o,
  input  logic                 vlane_store_dvalid_i,
  input  logic                 sdbuff_write_done_i,
  input  logic                 rd_done_i,
  output logic                 rd_start_o,
  output mcu_pkg::store_mode_t mode_o
);

  import mcu_pkg::*;

  typedef enum logic [1:0] {IDLE, BUFFED, WRITE, WAIT} state_t;

  state_t      state_q, state_d;
  lmul_code_t  emul;
  logic        emul_illegal;
  logic        accept;
  store_mode_t req_mode;

  emul_calc i_emul_calc (
    .sew_i        (sew_i),
    .lmul_i       (lmul_i),
    .data_width_i (data_width_i),
    .emul_o       (emul),
    .illegal_o    (emul_illegal)
  );

  // Unit is the fallback when neither mode bit is set
  assign req_mode = (strided_i && !unit_i) ? STORE_STRIDED : STORE_UNIT;
  assign accept   = (state_q == IDLE) && st_vld_i;

  ////////////////////////////////////////////////////////////////////////////
  // Configuration capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mode_o          <= STORE_UNIT;
      cfg_data_sew_o  <= '0;
      cfg_data_lmul_o <= '0;
      cfg_illegal_o   <= 1'b0;
    end else if (accept) begin
      mode_o          <= req_mode;
      cfg_data_sew_o  <= data_width_i;
      cfg_data_lmul_o <= emul;
      cfg_illegal_o   <= emul_illegal;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d           = state_q;
    st_rdy_o          = 1'b0;
    baseaddr_set_o    = 1'b0;
    cfg_update_o      = 1'b0;
    cntr_rst_o        = 1'b0;
    rd_start_o        = 1'b0;
    vlane_store_rdy_o = 1'b0;
    sbuff_wen_o       = 1'b0;
    case (state_q)
      IDLE: begin
        st_rdy_o       = 1'b1;
        baseaddr_set_o = st_vld_i;
        if (st_vld_i) begin
          state_d = BUFFED;
        end
      end
      // Configuration is stable now, let the buffer array latch it
      BUFFED: begin
        cfg_update_o = 1'b1;
        cntr_rst_o   = 1'b1;
        rd_start_o   = 1'b1;
        state_d      = WRITE;
      end
      WRITE: begin
        vlane_store_rdy_o = 1'b1;
        sbuff_wen_o       = vlane_store_dvalid_i;
        if (vlane_store_dvalid_i && sdbuff_write_done_i) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (rd_done_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // No new read sequence may start while the scheduler sees us as free
  assert property (@(posedge clk) disable iff (!rstn) !(rd_start_o && st_rdy_o));

endmodule : store_write_fsm

// ==== store_read_fsm.sv ====
/*
  Store read sequencer: drains the store buffer to the AXI write master
  in unit or strided mode and raises the write-start pulse
*/
`timescale 1ns/1ps

module store_read_fsm (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 rd_start_i,
  input  mcu_pkg::store_mode_t mode_i,
  output logic                 rd_done_o,
  input  logic                 sdbuff_read_rdy_i,
  input  logic                 sdbuff_read_done_i,
  input  logic                 wr_tready_i,
  input  logic                 ctrl_wdone_i,
  output logic                 sdbuff_ren_o,
  output logic                 baseaddr_update_o,
  output logic                 ctrl_wstart_o,
  rd_pipe_if.seq               p
);

  import mcu_pkg::*;

  typedef enum logic [1:0] {IDLE, UNIT, STRIDED, STRIDED_WAIT} state_t;

  state_t state_q, state_d;
  logic   wstart;
  logic   wstart_q;
  logic   back_pressure;

  assign back_pressure = p.tvalid && !wr_tready_i;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q  <= IDLE;
      wstart_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      wstart_q <= wstart;
    end
  end

  // Rising edge of the sending level
  assign ctrl_wstart_o = wstart && !wstart_q;

  ////////////////////////////////////////////////////////////////////////////
  // Next state and buffer read control
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d           = state_q;
    rd_done_o         = 1'b0;
    wstart            = 1'b0;
    sdbuff_ren_o      = 1'b0;
    baseaddr_update_o = 1'b0;
    p.rvalid          = 1'b0;
    p.stall           = 1'b0;
    p.invalidate      = 1'b0;
    case (state_q)
      IDLE: begin
        if (rd_start_i) begin
          state_d = (mode_i == STORE_STRIDED) ? STRIDED : UNIT;
        end
      end
      UNIT, STRIDED: begin
        wstart = 1'b1;
        if (sdbuff_read_rdy_i) begin
          // Stop fetching once the last word is out
          p.rvalid     = !sdbuff_read_done_i;
          sdbuff_ren_o = !sdbuff_read_done_i;
          if (back_pressure) begin
            p.stall      = 1'b1;
            sdbuff_ren_o = 1'b0;
          end
        end else begin
          // Buffer not ready, freeze and hide the valid
          p.stall      = 1'b1;
          p.invalidate = 1'b1;
        end
        if (state_q == UNIT) begin
          if (ctrl_wdone_i) begin
            state_d   = IDLE;
            rd_done_o = 1'b1;
          end
        end else if (sdbuff_read_rdy_i && p.tvalid && wr_tready_i) begin
          state_d = STRIDED_WAIT;
        end
      end
      // One element in flight, hold the line and hide the next word
      STRIDED_WAIT: begin
        p.stall      = 1'b1;
        p.invalidate = 1'b1;
        if (ctrl_wdone_i) begin
          if (p.empty) begin
            state_d   = IDLE;
            rd_done_o = 1'b1;
          end else begin
            baseaddr_update_o = 1'b1;
            state_d           = STRIDED;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // The buffer must not advance while the master holds a beat
  assert property (@(posedge clk) disable iff (!rstn) back_pressure |-> !sdbuff_ren_o);

endmodule : store_read_fsm

// ==== sdbuff_read_pipe.sv ====
/*
  Read-valid delay line of the store buffer, gates the AXI write valid
*/
`timescale 1ns/1ps

module sdbuff_read_pipe (
  input  logic     clk,
  input  logic     rstn,
  rd_pipe_if.pipe  p
);

  import mcu_pkg::*;

  logic [RVALID_DEPTH-1:0] rvalid_q;

  // Shift freezes while stalled
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rvalid_q <= '0;
    end else if (!p.stall) begin
      rvalid_q <= {rvalid_q[RVALID_DEPTH-2:0], p.rvalid};
    end
  end

  // Buffer data is out two cycles after the read
  assign p.tvalid = rvalid_q[1] && !p.invalidate;
  assign p.empty  = (rvalid_q == '0);

endmodule : sdbuff_read_pipe

// ==== store_mcu.sv ====
/*
  Store side of the vector memory control unit, links both sequencers
  and the read-valid pipeline
*/
`timescale 1ns/1ps

module store_mcu (
  input  logic                 clk,
  input  logic                 rstn,
  // Scheduler
  input  logic                 st_vld_i,
  output logic                 st_rdy_o,
  input  logic                 unit_i,
  input  logic                 strided_i,
  input  mcu_pkg::width_code_t sew_i,
  input  mcu_pkg::lmul_code_t  lmul_i,
  input  mcu_pkg::width_code_t data_width_i,
  // Buffer array
  output logic                 cfg_update_o,
  output logic                 cntr_rst_o,
  output logic                 baseaddr_set_o,
  output logic                 baseaddr_update_o,
  output logic                 cfg_illegal_o,
  output mcu_pkg::width_code_t cfg_data_sew_o,
  output mcu_pkg::lmul_code_t  cfg_data_lmul_o,
  output logic                 sbuff_wen_o,
  output logic                 sdbuff_ren_o,
  input  logic                 sdbuff_write_done_i,
  input  logic                 sdbuff_read_rdy_i,
  input  logic                 sdbuff_read_done_i,
  // Vector lanes
  input  logic                 vlane_store_dvalid_i,
  output logic                 vlane_store_rdy_o,
  // AXI write master
  output logic                 ctrl_wstart_o,
  input  logic                 ctrl_wdone_i,
  output logic                 wr_tvalid_o,
  input  logic                 wr_tready_i
);

  logic                 rd_start;
  logic                 rd_done;
  mcu_pkg::store_mode_t mode;

  rd_pipe_if i_rd_pipe_if ();

  store_write_fsm i_store_write_fsm (
    .clk                  (clk),
    .rstn                 (rstn),
    .st_vld_i             (st_vld_i),
    .unit_i               (unit_i),
    .strided_i            (strided_i),
    .sew_i                (sew_i),
    .data_width_i         (data_width_i),
    .lmul_i               (lmul_i),
    .st_rdy_o             (st_rdy_o),
    .cfg_update_o         (cfg_update_o),
    .cntr_rst_o           (cntr_rst_o),
    .baseaddr_set_o       (baseaddr_set_o),
    .vlane_store_rdy_o    (vlane_store_rdy_o),
    .sbuff_wen_o          (sbuff_wen_o),
    .cfg_illegal_o        (cfg_illegal_o),
    .cfg_data_sew_o       (cfg_data_sew_o),
    .cfg_data_lmul_o      (cfg_data_lmul_o),
    .vlane_store_dvalid_i (vlane_store_dvalid_i),
    .sdbuff_write_done_i  (sdbuff_write_done_i),
    .rd_done_i            (rd_done),
    .rd_start_o           (rd_start),
    .mode_o               (mode)
  );

  store_read_fsm i_store_read_fsm (
    .clk                (clk),
    .rstn               (rstn),
    .rd_start_i         (rd_start),
    .mode_i             (mode),
    .rd_done_o          (rd_done),
    .sdbuff_read_rdy_i  (sdbuff_read_rdy_i),
    .sdbuff_read_done_i (sdbuff_read_done_i),
    .wr_tready_i        (wr_tready_i),
    .ctrl_wdone_i       (ctrl_wdone_i),
    .sdbuff_ren_o       (sdbuff_ren_o),
    .baseaddr_update_o  (baseaddr_update_o),
    .ctrl_wstart_o      (ctrl_wstart_o),
    .p                  (i_rd_pipe_if.seq)
  );

  sdbuff_read_pipe i_sdbuff_read_pipe (
    .clk  (clk),
    .rstn (rstn),
    .p    (i_rd_pipe_if.pipe)
  );

  assign wr_tvalid_o = i_rd_pipe_if.tvalid;

endmodule : store_mcu

// ==== tb_store_mcu.sv ====
/*
  Directed testbench for the store MCU with buffer array and AXI write
  master models, an EMUL reference and per-test result lines
*/
`timescale 1ns/1ps

module tb_store_mcu;

  import mcu_pkg::*;

  // 20 short unit runs and four longer ones stay well below this
  localparam int TIMEOUT_CYCLES = 2000;

  logic        clk;
  logic        rstn;
  logic        st_vld;
  logic        unit;
  logic        strided;
  width_code_t sew;
  lmul_code_t  lmul;
  width_code_t data_width;
  logic        sdbuff_write_done;
  logic        sdbuff_read_rdy;
  logic        sdbuff_read_done = 1'b0;
  logic        vlane_store_dvalid;
  logic        ctrl_wdone = 1'b0;
  logic        wr_tready;

  logic        st_rdy;
  logic        cfg_update;
  logic        cntr_rst;
  logic        baseaddr_set;
  logic        baseaddr_update;
  logic        cfg_illegal;
  width_code_t cfg_data_sew;
  lmul_code_t  cfg_data_lmul;
  logic        sbuff_wen;
  logic        sdbuff_ren;
  logic        vlane_store_rdy;
  logic        ctrl_wstart;
  logic        wr_tvalid;
  logic        beat;

  // Model settings and event counters
  int          n_elem      = 1;
  logic        strided_run = 1'b0;
  int          rd_cnt, beat_cnt, wen_cnt, wstart_cnt, upd_cnt, wdone_cnt, exp_upd;
  logic [2:0]  pipe_model;
  logic        elem_busy;
  int          cycles      = 0;
  int          err_cnt     = 0;
  int          tests_run   = 0;
  int          tests_failed = 0;
  int          test_errs;
  string       cur_test;
  integer      seed        = 32'h08dfaec4;

  store_mcu i_store_mcu (
    .clk (clk), .rstn (rstn),
    .st_vld_i (st_vld), .st_rdy_o (st_rdy), .unit_i (unit), .strided_i (strided),
    .sew_i (sew), .lmul_i (lmul), .data_width_i (data_width),
    .cfg_update_o (cfg_update), .cntr_rst_o (cntr_rst), .baseaddr_set_o (baseaddr_set),
    .baseaddr_update_o (baseaddr_update), .cfg_illegal_o (cfg_illegal),
    .cfg_data_sew_o (cfg_data_sew), .cfg_data_lmul_o (cfg_data_lmul),
    .sbuff_wen_o (sbuff_wen), .sdbuff_ren_o (sdbuff_ren),
    .sdbuff_write_done_i (sdbuff_write_done), .sdbuff_read_rdy_i (sdbuff_read_rdy),
    .sdbuff_read_done_i (sdbuff_read_done),
    .vlane_store_dvalid_i (vlane_store_dvalid), .vlane_store_rdy_o (vlane_store_rdy),
    .ctrl_wstart_o (ctrl_wstart), .ctrl_wdone_i (ctrl_wdone),
    .wr_tvalid_o (wr_tvalid), .wr_tready_i (wr_tready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the store sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Buffer array and AXI write master models
  ////////////////////////////////////////////////////////////////////////////

  assign beat = wr_tvalid && wr_tready;

  always @(posedge clk or negedge rstn) begin
    if (!rstn || cntr_rst) begin
      rd_cnt           <= 0;
      beat_cnt         <= 0;
      wen_cnt          <= 0;
      wstart_cnt       <= 0;
      upd_cnt          <= 0;
      wdone_cnt        <= 0;
      exp_upd          <= 0;
      pipe_model       <= '0;
      elem_busy        <= 1'b0;
      sdbuff_read_done <= 1'b0;
      ctrl_wdone       <= 1'b0;
    end else begin
      rd_cnt           <= rd_cnt + int'(sdbuff_ren);
      sdbuff_read_done <= (rd_cnt + int'(sdbuff_ren) >= n_elem);
      beat_cnt         <= beat_cnt + int'(beat);
      // Unit mode finishes once, strided mode after every element
      if (strided_run) begin
        ctrl_wdone <= beat;
      end else begin
        ctrl_wdone <= beat && (beat_cnt + 1 == n_elem);
      end
      wen_cnt    <= wen_cnt + int'(sbuff_wen);
      wstart_cnt <= wstart_cnt + int'(ctrl_wstart);
      upd_cnt    <= upd_cnt + int'(baseaddr_update);
      wdone_cnt  <= wdone_cnt + int'(ctrl_wdone);
      if (ctrl_wdone) begin
        elem_busy <= 1'b0;
      end else if (strided_run && beat) begin
        elem_busy <= 1'b1;
      end
      // Shadow of the read-valid line, held while an element is in flight
      if (!(elem_busy || (wr_tvalid && !wr_tready) || !sdbuff_read_rdy)) begin
        pipe_model <= {pipe_model[1:0], sdbuff_ren};
      end
      if (strided_run && ctrl_wdone && pipe_model != '0) begin
        exp_upd <= exp_upd + 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks and reference
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      err_cnt++;
      $display("error %s: %s expected %0b actual %0b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_width(input string what, input width_code_t exp, input width_code_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("error %s: %s expected %0d actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic check_lmul(input string what, input lmul_code_t exp, input lmul_code_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("error %s: %s expected %0d actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      err_cnt++;
      $display("error %s: %s expected %0d actual %0d", cur_test, what, exp, act);
    end
  endtask

  // EMUL = LMUL * EEW / SEW, kept in eighths so fractions stay integer
  function automatic void ref_emul(input width_code_t s, input lmul_code_t l,
                                   input width_code_t d, output lmul_code_t emul,
                                   output logic illegal);
    int lmul_x8;
    int emul_x8;
    case (l)
      3'd0: lmul_x8 = 8;
      3'd1: lmul_x8 = 16;
      3'd2: lmul_x8 = 32;
      3'd3: lmul_x8 = 64;
      3'd5: lmul_x8 = 1;
      3'd6: lmul_x8 = 2;
      3'd7: lmul_x8 = 4;
      default: lmul_x8 = 0;
    endcase
    emul_x8 = lmul_x8 * (8 << d) / (8 << s);
    illegal = (s == 3) || (d == 3) || (l == 4) || (emul_x8 < 1) || (emul_x8 > 64);
    case (emul_x8)
      1:  emul = 3'd5;
      2:  emul = 3'd6;
      4:  emul = 3'd7;
      8:  emul = 3'd0;
      16: emul = 3'd1;
      32: emul = 3'd2;
      64: emul = 3'd3;
      default: emul = 3'd0;
    endcase
  endfunction

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = err_cnt;
    tests_run++;
  endtask

  task automatic end_test();
    if (err_cnt != test_errs) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", cur_test, err_cnt - test_errs);
    end else begin
      $display("test %s: ok", cur_test);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Returns on the edge that ends the cycle after acceptance
  task automatic start_store(input logic strd, input width_code_t s, input lmul_code_t l,
                             input width_code_t d);
    @(posedge clk);
    st_vld     <= 1'b1;
    unit       <= !strd;
    strided    <= strd;
    sew        <= s;
    lmul       <= l;
    data_width <= d;
    @(posedge clk);
    check_bit("st_rdy at accept", 1'b1, st_rdy);
    check_bit("baseaddr_set at accept", 1'b1, baseaddr_set);
    st_vld <= 1'b0;
    @(posedge clk);
    check_bit("cfg_update", 1'b1, cfg_update);
    check_bit("cntr_rst", 1'b1, cntr_rst);
    check_bit("st_rdy while busy", 1'b0, st_rdy);
    check_bit("baseaddr_set after accept", 1'b0, baseaddr_set);
    check_width("cfg_data_sew", d, cfg_data_sew);
  endtask

  task automatic feed_lanes(input int n);
    for (int i = 0; i < n; i++) begin
      vlane_store_dvalid <= 1'b1;
      sdbuff_write_done  <= (i == n - 1);
      @(posedge clk);
      check_bit("vlane_store_rdy", 1'b1, vlane_store_rdy);
    end
    vlane_store_dvalid <= 1'b0;
    sdbuff_write_done  <= 1'b0;
  endtask

  task automatic wait_idle();
    @(posedge clk);
    while (!st_rdy) begin
      @(posedge clk);
    end
  endtask

  task automatic test_reset();
    begin_test("reset");
    @(posedge clk);
    check_bit("st_rdy", 1'b1, st_rdy);
    check_bit("cfg_update", 1'b0, cfg_update);
    check_bit("cntr_rst", 1'b0, cntr_rst);
    check_bit("baseaddr_set", 1'b0, baseaddr_set);
    check_bit("baseaddr_update", 1'b0, baseaddr_update);
    check_bit("cfg_illegal", 1'b0, cfg_illegal);
    check_bit("sbuff_wen", 1'b0, sbuff_wen);
    check_bit("sdbuff_ren", 1'b0, sdbuff_ren);
    check_bit("vlane_store_rdy", 1'b0, vlane_store_rdy);
    check_bit("ctrl_wstart", 1'b0, ctrl_wstart);
    check_bit("wr_tvalid", 1'b0, wr_tvalid);
    check_width("cfg_data_sew", '0, cfg_data_sew);
    check_lmul("cfg_data_lmul", '0, cfg_data_lmul);
    end_test();
  endtask

  task automatic test_emul_capture();
    width_code_t s;
    width_code_t d;
    lmul_code_t  l;
    lmul_code_t  exp_emul;
    logic        exp_ill;
    begin_test("emul_capture");
    n_elem      = 1;
    strided_run = 1'b0;
    for (int i = 0; i < 20; i++) begin
      s = width_code_t'($random(seed) & 32'h3);
      l = lmul_code_t'($random(seed) & 32'h7);
      d = width_code_t'($random(seed) & 32'h3);
      ref_emul(s, l, d, exp_emul, exp_ill);
      start_store(1'b0, s, l, d);
      check_bit("cfg_illegal", exp_ill, cfg_illegal);
      if (!exp_ill) begin
        check_lmul("cfg_data_lmul", exp_emul, cfg_data_lmul);
      end
      feed_lanes(1);
      wait_idle();
    end
    end_test();
  endtask

  task automatic test_unit_store();
    begin_test("unit_store");
    n_elem      = 5;
    strided_run = 1'b0;
    start_store(1'b0, 3'd2, 3'd0, 3'd2);
    feed_lanes(5);
    wait_idle();
    check_count("sbuff_wen pulses", 5, wen_cnt);
    check_count("ctrl_wstart pulses", 1, wstart_cnt);
    check_count("AXI beats", 5, beat_cnt);
    check_count("ctrl_wdone pulses", 1, wdone_cnt);
    end_test();
  endtask

  task automatic test_back_pressure();
    begin_test("back_pressure");
    n_elem      = 4;
    strided_run = 1'b0;
    wr_tready  <= 1'b0;
    start_store(1'b0, 3'd1, 3'd1, 3'd1);
    feed_lanes(4);
    while (!wr_tvalid) begin
      @(posedge clk);
    end
    repeat (5) begin
      @(posedge clk);
      check_bit("wr_tvalid held", 1'b1, wr_tvalid);
      check_bit("sdbuff_ren held", 1'b0, sdbuff_ren);
    end
    wr_tready <= 1'b1;
    wait_idle();
    check_count("AXI beats", 4, beat_cnt);
    end_test();
  endtask

  task automatic test_buffer_not_ready();
    begin_test("buffer_not_ready");
    n_elem           = 3;
    strided_run      = 1'b0;
    sdbuff_read_rdy <= 1'b0;
    start_store(1'b0, 3'd0, 3'd0, 3'd0);
    feed_lanes(3);
    repeat (5) begin
      @(posedge clk);
      check_bit("wr_tvalid", 1'b0, wr_tvalid);
      check_bit("sdbuff_ren", 1'b0, sdbuff_ren);
    end
    sdbuff_read_rdy <= 1'b1;
    wait_idle();
    check_count("AXI beats", 3, beat_cnt);
    end_test();
  endtask

  // The sequencer stays in the sending state after the last element
  task automatic test_strided_store();
    begin_test("strided_store");
    n_elem      = 4;
    strided_run = 1'b1;
    start_store(1'b1, 3'd2, 3'd0, 3'd2);
    feed_lanes(4);
    while (wdone_cnt < 4) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    check_count("AXI beats", 4, beat_cnt);
    check_count("sbuff_wen pulses", 4, wen_cnt);
    check_count("baseaddr_update pulses", exp_upd, upd_cnt);
    check_count("ctrl_wstart pulses", exp_upd + 1, wstart_cnt);
    end_test();
  endtask

  initial begin
    rstn               = 1'b0;
    st_vld             = 1'b0;
    unit               = 1'b0;
    strided            = 1'b0;
    sew                = '0;
    lmul               = '0;
    data_width         = '0;
    sdbuff_write_done  = 1'b0;
    sdbuff_read_rdy    = 1'b1;
    vlane_store_dvalid = 1'b0;
    wr_tready          = 1'b1;
    repeat (3) @(posedge clk);
    rstn <= 1'b1;

    test_reset();
    test_emul_capture();
    test_unit_store();
    test_back_pressure();
    test_buffer_not_ready();
    test_strided_store();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : tb_store_mcu

// ==== build.f ====
mcu_pkg.sv
rd_pipe_if.sv
emul_calc.sv
store_write_fsm.sv
store_read_fsm.sv
sdbuff_read_pipe.sv
store_mcu.sv
tb_store_mcu.sv

// ==== Bender.yml ====
package:
  name: store_mcu

sources:
  - mcu_pkg.sv
  - rd_pipe_if.sv
  - emul_calc.sv
  - store_write_fsm.sv
  - store_read_fsm.sv
  - sdbuff_read_pipe.sv
  - store_mcu.sv
  - target: test
    files:
      - tb_store_mcu.sv
